// ==== logic/lcd_pkg.sv ====
`default_nettype none

package lcd_pkg;

	// mode bits as seen on the config input, msb first
	typedef struct packed {
		logic two_line;   // N bit of function set
		logic font_5x10;  // F bit of function set
		logic display_on;
		logic cursor_on;
		logic blink_on;
		logic increment;  // I/D of entry mode
		logic shift;      // S of entry mode
	} lcd_config_t;

	// one write on the panel bus
	typedef struct packed {
		logic       rs;    // 1 selects data register
		logic       rw;
		logic [7:0] data;
	} lcd_word_t;

	// instruction base codes, argument bits are or-ed in by the user
	typedef enum logic [7:0] {
		CLEAR        = 8'h01,
		HOME         = 8'h02,
		ENTRY_MODE   = 8'h04,
		DISPLAY_CTRL = 8'h08,
		FUNCTION_SET = 8'h30,  // DL set, 8-bit bus
		SET_DDRAM    = 8'h80
	} lcd_instr_e;

	// panel timing in microseconds
	localparam int T_POWERUP        = 500;
	localparam int T_PULSE_SETUP    = 1;     // data to e rising
	localparam int T_PULSE_HIGH_END = 14;    // e falling, from command
	localparam int T_WRITE          = 50;    // normal instruction or data
	localparam int T_CLEAR          = 2000;  // clear and home
	localparam int T_INIT_PULSE     = 10;

	// wait after each of the four init instructions
	localparam int T_INIT_WAIT [4] = '{50, 50, 200, 100};

	// ddram offset of the second line
	localparam logic [7:0] LINE2_ADDR = 8'h40;

endpackage

`default_nettype wire

// ==== logic/char_fifo.sv ====
`timescale 1ns/1ps
`default_nettype none

module char_fifo #(
	parameter int DEPTH = 16
) (
	input  logic       clk,
	input  logic       reset,
	input  logic [7:0] wr_data,
	input  logic       write,
	input  logic       read,
	output logic [7:0] rd_data,
	output logic       empty,
	output logic       full
);

	localparam int AW = $clog2(DEPTH);

	logic [7:0]  mem [DEPTH];
	logic [AW:0] wr_ptr;  // extra msb tells full from empty
	logic [AW:0] rd_ptr;
	logic        do_write;
	logic        do_read;

	assign do_write = write && !full;  // strobe into a full buffer is lost
	assign do_read  = read && !empty;

	assign empty = (wr_ptr == rd_ptr);
	assign full  = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);

	// head of the queue straight from the array
	assign rd_data = mem[rd_ptr[AW-1:0]];

	always_ff @(posedge clk) begin
		if (do_write) begin
			mem[wr_ptr[AW-1:0]] <= wr_data;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end else begin
			if (do_write) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (do_read) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

// ==== logic/text_formatter.sv ====
`timescale 1ns/1ps
`default_nettype none

module text_formatter #(
	parameter int LINE_LEN = 16
) (
	input  logic                 clk,
	input  logic                 reset,
	input  lcd_pkg::lcd_config_t cfg,
	input  logic [7:0]           fifo_data,
	input  logic                 fifo_empty,
	output logic                 fifo_read,
	input  logic                 busy,
	output lcd_pkg::lcd_word_t   cmd,
	output logic                 cmd_write
);

	localparam int COL_W = $clog2(LINE_LEN + 1);
	localparam logic [COL_W-1:0] WRAP_COL = COL_W'(LINE_LEN);
	localparam logic [7:0] CHAR_LF = 8'h0A;
	localparam logic [7:0] CHAR_FF = 8'h0C;
	localparam logic [7:0] CHAR_SPACE = 8'h20;  // first printable code

	typedef enum logic [2:0] {
		IDLE,
		FETCH,
		SEND_ADDR,
		SEND_CHAR,
		SEND_CLEAR
	} state_e;

	state_e           state;
	logic [7:0]       ch;         // character held between address and data
	logic             line;
	logic [COL_W-1:0] col;        // may sit at WRAP_COL until the next char
	logic             next_line;
	logic             can_send;
	logic [7:0]       line_base;

	// a strobe just sent has not raised busy yet
	assign can_send  = !busy && !cmd_write;
	assign next_line = cfg.two_line ? ~line : 1'b0;
	assign line_base = line ? lcd_pkg::LINE2_ADDR : 8'h00;

	always_ff @(posedge clk) begin
		if (reset) begin
			state     <= IDLE;
			fifo_read <= 1'b0;
			cmd_write <= 1'b0;
			line      <= 1'b0;
			col       <= '0;
		end else begin
			fifo_read <= 1'b0;
			cmd_write <= 1'b0;
			case (state)
				IDLE: begin
					if (!fifo_empty && can_send) begin
						fifo_read <= 1'b1;  // pops at the end of FETCH
						state     <= FETCH;
					end
				end
				FETCH: begin
					if (fifo_data == CHAR_FF) begin
						state <= SEND_CLEAR;
					end else if (fifo_data == CHAR_LF) begin
						line  <= next_line;
						col   <= '0;
						state <= IDLE;
					end else if (fifo_data < CHAR_SPACE) begin
						state <= IDLE;  // other control codes dropped
					end else if (col == WRAP_COL) begin
						line  <= next_line;
						col   <= '0;
						state <= SEND_ADDR;
					end else if (col == '0) begin
						state <= SEND_ADDR;
					end else begin
						state <= SEND_CHAR;
					end
				end
				SEND_ADDR: begin
					if (can_send) begin
						cmd_write <= 1'b1;
						state     <= SEND_CHAR;
					end
				end
				SEND_CHAR: begin
					if (can_send) begin
						cmd_write <= 1'b1;
						col       <= col + 1'b1;
						state     <= IDLE;
					end
				end
				SEND_CLEAR: begin
					if (can_send) begin
						cmd_write <= 1'b1;
						line      <= 1'b0;  // panel clear homes the cursor too
						col       <= '0;
						state     <= IDLE;
					end
				end
				default: begin
					state <= IDLE;
				end
			endcase
		end
	end

	// instruction words, loaded together with cmd_write
	always_ff @(posedge clk) begin
		if (state == FETCH) begin
			ch <= fifo_data;
		end
		if (can_send) begin
			case (state)
				SEND_ADDR: begin
					cmd <= '{rs: 1'b0, rw: 1'b0, data: lcd_pkg::SET_DDRAM | line_base};
				end
				SEND_CHAR: begin
					cmd <= '{rs: 1'b1, rw: 1'b0, data: ch};
				end
				SEND_CLEAR: begin
					cmd <= '{rs: 1'b0, rw: 1'b0, data: lcd_pkg::CLEAR};
				end
				default: begin
					cmd <= cmd;
				end
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== logic/lcd_controller.sv ====
`timescale 1ns/1ps
`default_nettype none

module lcd_controller #(
	parameter int CLK_PER_US = 50
) (
	input  logic                 clk,
	input  logic                 reset,
	input  lcd_pkg::lcd_config_t cfg,
	input  lcd_pkg::lcd_word_t   cmd,
	input  logic                 cmd_write,
	output logic                 busy,
	output logic                 lcd_e,
	output logic                 lcd_rs,
	output logic                 lcd_rw,
	output logic [7:0]           lcd_data
);

	localparam int LONGEST = (lcd_pkg::T_CLEAR > lcd_pkg::T_POWERUP) ?
		lcd_pkg::T_CLEAR : lcd_pkg::T_POWERUP;
	localparam int CNT_W = $clog2(LONGEST * CLK_PER_US + 1);

	// init schedule: each step is a pulse followed by its wait
	localparam int STEP_0 = (lcd_pkg::T_INIT_PULSE + lcd_pkg::T_INIT_WAIT[0]) * CLK_PER_US;
	localparam int STEP_1 = (lcd_pkg::T_INIT_PULSE + lcd_pkg::T_INIT_WAIT[1]) * CLK_PER_US;
	localparam int STEP_2 = (lcd_pkg::T_INIT_PULSE + lcd_pkg::T_INIT_WAIT[2]) * CLK_PER_US;
	localparam int STEP_3 = (lcd_pkg::T_INIT_PULSE + lcd_pkg::T_INIT_WAIT[3]) * CLK_PER_US;

	localparam logic [CNT_W-1:0] INIT_START_1 = CNT_W'(STEP_0);
	localparam logic [CNT_W-1:0] INIT_START_2 = CNT_W'(STEP_0 + STEP_1);
	localparam logic [CNT_W-1:0] INIT_START_3 = CNT_W'(STEP_0 + STEP_1 + STEP_2);
	localparam logic [CNT_W-1:0] INIT_LAST = CNT_W'(STEP_0 + STEP_1 + STEP_2 + STEP_3 - 1);
	localparam logic [CNT_W-1:0] PULSE_LEN = CNT_W'(lcd_pkg::T_INIT_PULSE * CLK_PER_US);
	localparam logic [CNT_W-1:0] PWR_LAST = CNT_W'(lcd_pkg::T_POWERUP * CLK_PER_US - 1);

	// normal write, counted from the first cycle with pins valid
	localparam logic [CNT_W-1:0] SETUP_LAST = CNT_W'(lcd_pkg::T_PULSE_SETUP * CLK_PER_US - 1);
	localparam logic [CNT_W-1:0] HIGH_LAST =
		CNT_W'(lcd_pkg::T_PULSE_HIGH_END * CLK_PER_US - 1);
	localparam logic [CNT_W-1:0] WRITE_LAST = CNT_W'(lcd_pkg::T_WRITE * CLK_PER_US - 1);
	localparam logic [CNT_W-1:0] CLEAR_LAST = CNT_W'(lcd_pkg::T_CLEAR * CLK_PER_US - 1);

	typedef enum logic [1:0] {
		POWER_UP,
		INIT,
		IDLE,
		WRITE
	} state_e;

	state_e           state;
	logic [CNT_W-1:0] cnt;
	logic [CNT_W-1:0] init_cnt;   // init position of the next cycle
	logic [CNT_W-1:0] init_base;
	logic [1:0]       init_step;
	logic             init_e;
	logic [7:0]       init_word;
	logic             long_cmd;

	always_comb begin
		init_cnt = (state == INIT) ? cnt + 1'b1 : '0;
		if (init_cnt >= INIT_START_3) begin
			init_step = 2'd3;
			init_base = INIT_START_3;
		end else if (init_cnt >= INIT_START_2) begin
			init_step = 2'd2;
			init_base = INIT_START_2;
		end else if (init_cnt >= INIT_START_1) begin
			init_step = 2'd1;
			init_base = INIT_START_1;
		end else begin
			init_step = 2'd0;
			init_base = '0;
		end
		init_e = (init_cnt - init_base) < PULSE_LEN;  // e high at start of step
		case (init_step)
			2'd0: init_word = lcd_pkg::FUNCTION_SET |
				{4'b0000, cfg.two_line, cfg.font_5x10, 2'b00};
			2'd1: init_word = lcd_pkg::DISPLAY_CTRL |
				{5'b00000, cfg.display_on, cfg.cursor_on, cfg.blink_on};
			2'd2: init_word = lcd_pkg::CLEAR;
			default: init_word = lcd_pkg::ENTRY_MODE |
				{6'b000000, cfg.increment, cfg.shift};
		endcase
	end

	// clear and home need the long execution time
	assign long_cmd = !lcd_rs &&
		(lcd_data == lcd_pkg::CLEAR || {lcd_data[7:1], 1'b0} == lcd_pkg::HOME);

	always_ff @(posedge clk) begin
		if (reset) begin
			state    <= POWER_UP;
			cnt      <= '0;
			busy     <= 1'b1;  // held until init is through
			lcd_e    <= 1'b0;
			lcd_rs   <= 1'b0;
			lcd_rw   <= 1'b0;
			lcd_data <= '0;
		end else begin
			case (state)
				POWER_UP: begin
					if (cnt == PWR_LAST) begin
						cnt      <= '0;
						lcd_e    <= init_e;
						lcd_data <= init_word;
						state    <= INIT;
					end else begin
						cnt <= cnt + 1'b1;
					end
				end
				INIT: begin
					if (cnt == INIT_LAST) begin
						cnt   <= '0;
						lcd_e <= 1'b0;
						busy  <= 1'b0;
						state <= IDLE;
					end else begin
						cnt      <= cnt + 1'b1;
						lcd_e    <= init_e;
						lcd_data <= init_word;
					end
				end
				IDLE: begin
					if (cmd_write) begin
						lcd_rs   <= cmd.rs;
						lcd_rw   <= cmd.rw;
						lcd_data <= cmd.data;
						busy     <= 1'b1;
						cnt      <= '0;
						state    <= WRITE;
					end
				end
				WRITE: begin
					cnt <= cnt + 1'b1;
					if (cnt == SETUP_LAST) begin
						lcd_e <= 1'b1;
					end
					if (cnt == HIGH_LAST) begin
						lcd_e <= 1'b0;  // panel latches on this edge
					end
					if (cnt == (long_cmd ? CLEAR_LAST : WRITE_LAST)) begin
						cnt   <= '0;
						busy  <= 1'b0;
						state <= IDLE;
					end
				end
				default: begin
					state <= IDLE;
				end
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== logic/lcd_text_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module lcd_text_top #(
	parameter int CLK_PER_US = 50,
	parameter int FIFO_DEPTH = 16,  // power of two
	parameter int LINE_LEN   = 16
) (
	input  logic                 clk,
	input  logic                 reset,
	input  lcd_pkg::lcd_config_t cfg,
	input  logic [7:0]           char_data,
	input  logic                 char_write,
	output logic                 char_full,
	output logic                 lcd_e,
	output logic                 lcd_rs,
	output logic                 lcd_rw,
	output logic [7:0]           lcd_data,
	output logic                 ready
);

	logic [7:0]         fifo_data;
	logic               fifo_empty;
	logic               fifo_read;
	lcd_pkg::lcd_word_t cmd;
	logic               cmd_write;
	logic               busy;

	assign ready = ~busy;  // init done and no write in flight

	char_fifo #(
		.DEPTH(FIFO_DEPTH)
	) char_fifo_inst (
		.clk(clk),
		.reset(reset),
		.wr_data(char_data),
		.write(char_write),
		.read(fifo_read),
		.rd_data(fifo_data),
		.empty(fifo_empty),
		.full(char_full)
	);

	text_formatter #(
		.LINE_LEN(LINE_LEN)
	) text_formatter_inst (
		.clk(clk),
		.reset(reset),
		.cfg(cfg),
		.fifo_data(fifo_data),
		.fifo_empty(fifo_empty),
		.fifo_read(fifo_read),
		.busy(busy),
		.cmd(cmd),
		.cmd_write(cmd_write)
	);

	lcd_controller #(
		.CLK_PER_US(CLK_PER_US)
	) lcd_controller_inst (
		.clk(clk),
		.reset(reset),
		.cfg(cfg),
		.cmd(cmd),
		.cmd_write(cmd_write),
		.busy(busy),
		.lcd_e(lcd_e),
		.lcd_rs(lcd_rs),
		.lcd_rw(lcd_rw),
		.lcd_data(lcd_data)
	);

endmodule

`default_nettype wire

// ==== dv/lcd_clock_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module lcd_clock_gen #(
	parameter int PERIOD_NS = 8
) (
	output logic clk
);

	initial begin
		clk = 1'b0;
		forever #(PERIOD_NS / 2) clk = ~clk;
	end

endmodule

`default_nettype wire

// ==== dv/lcd_text_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module lcd_text_tb;

	localparam int U        = 1;  // cycles per microsecond
	localparam int LINE_LEN = 4;
	localparam int SETTLE   = 2 * lcd_pkg::T_WRITE * U + 20;
	localparam int INIT_US  = lcd_pkg::T_POWERUP + 4 * lcd_pkg::T_INIT_PULSE +
		lcd_pkg::T_INIT_WAIT[0] + lcd_pkg::T_INIT_WAIT[1] +
		lcd_pkg::T_INIT_WAIT[2] + lcd_pkg::T_INIT_WAIT[3];

	typedef struct packed {
		lcd_pkg::lcd_config_t cfg;
		logic [7:0]           ch;
		logic                 burst;  // strobe without waiting on char_full
	} row_t;

	logic                 clk;
	logic                 reset;
	lcd_pkg::lcd_config_t cfg;
	logic [7:0]           char_data;
	logic                 char_write;
	logic                 char_full;
	logic                 lcd_e;
	logic                 lcd_rs;
	logic                 lcd_rw;
	logic [7:0]           lcd_data;
	logic                 ready;

	row_t               rows [$];
	lcd_pkg::lcd_word_t log_q [$];  // every write seen on the bus
	lcd_pkg::lcd_word_t exp_q [$];
	int                 errors;
	int                 checked;
	logic               rows_built;
	logic               m_line;      // cursor of the reference model
	int                 m_col;
	logic               m_two_line;

	lcd_clock_gen #(.PERIOD_NS(8)) lcd_clock_gen_inst (.clk(clk));

	lcd_text_top #(
		.CLK_PER_US(U),
		.FIFO_DEPTH(8),
		.LINE_LEN(LINE_LEN)
	) lcd_text_top_inst (
		.clk(clk),
		.reset(reset),
		.cfg(cfg),
		.char_data(char_data),
		.char_write(char_write),
		.char_full(char_full),
		.lcd_e(lcd_e),
		.lcd_rs(lcd_rs),
		.lcd_rw(lcd_rw),
		.lcd_data(lcd_data),
		.ready(ready)
	);

	task automatic add_text(input lcd_pkg::lcd_config_t c, input string s, input logic b);
		int i;
		for (i = 0; i < s.len(); i++) begin
			rows.push_back('{cfg: c, ch: s[i], burst: b});
		end
	endtask

	task automatic expect_word(input logic rs, input logic [7:0] data);
		exp_q.push_back('{rs: rs, rw: 1'b0, data: data});
	endtask

	// init sequence in datasheet order
	task automatic expect_init(input lcd_pkg::lcd_config_t c);
		expect_word(1'b0, {3'b001, 1'b1, c.two_line, c.font_5x10, 2'b00});  // 8-bit bus
		expect_word(1'b0, {5'b00001, c.display_on, c.cursor_on, c.blink_on});
		expect_word(1'b0, 8'h01);
		expect_word(1'b0, {6'b000001, c.increment, c.shift});
	endtask

	task automatic model_char(input logic [7:0] ch);
		logic [7:0] base;
		if (ch == 8'h0C) begin
			expect_word(1'b0, 8'h01);  // clear also homes the cursor
			m_line = 1'b0;
			m_col  = 0;
		end else if (ch == 8'h0A) begin
			m_line = m_two_line ? !m_line : 1'b0;
			m_col  = 0;
		end else if (ch >= 8'h20) begin
			if (m_col == LINE_LEN) begin
				m_line = m_two_line ? !m_line : 1'b0;
				m_col  = 0;
			end
			if (m_col == 0) begin
				base = m_line ? lcd_pkg::LINE2_ADDR : 8'h00;
				expect_word(1'b0, 8'h80 | base);
			end
			expect_word(1'b1, ch);
			m_col++;
		end
	endtask

	task automatic restart(input lcd_pkg::lcd_config_t c);
		cfg        = c;
		reset      = 1'b1;
		char_write = 1'b0;
		m_line     = 1'b0;
		m_col      = 0;
		m_two_line = c.two_line;
		expect_init(c);
		repeat (4) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
		@(negedge clk);
		while (!ready) @(negedge clk);
		if (log_q.size() != exp_q.size()) begin
			errors++;
			$display("[ERROR] %0t: ready rose after %0d init writes, expected 4",
				$time, log_q.size() - checked);
		end
	endtask

	// wait for a quiet bus and compare the writes since the last check
	task automatic finish_phase();
		int i;
		while (log_q.size() < exp_q.size()) @(negedge clk);
		while (!ready) @(negedge clk);
		repeat (SETTLE) @(negedge clk);
		if (log_q.size() != exp_q.size()) begin
			errors++;
			$display("[ERROR] %0t: captured %0d bus writes, expected %0d",
				$time, log_q.size(), exp_q.size());
		end
		for (i = checked; i < exp_q.size(); i++) begin
			if (log_q[i] != exp_q[i]) begin
				errors++;
				$display("[ERROR] %0t: write %0d expected rs=%0b rw=%0b data=%02h", $time, i,
					exp_q[i].rs, exp_q[i].rw, exp_q[i].data);
				$display("[ERROR] %0t: write %0d got rs=%0b rw=%0b data=%02h", $time, i,
					log_q[i].rs, log_q[i].rw, log_q[i].data);
			end
		end
		while (log_q.size() > exp_q.size()) log_q.pop_back();
		checked = exp_q.size();
	endtask

	task automatic strobe(input logic [7:0] ch, output logic accepted);
		char_data  = ch;
		char_write = 1'b1;
		accepted   = !char_full;  // full only moves on the rising edge
		@(negedge clk);
		char_write = 1'b0;
	endtask

	// the panel latches on the falling edge of e
	initial begin
		forever begin
			@(negedge lcd_e);
			@(negedge clk);
			if (!reset) begin
				log_q.push_back('{rs: lcd_rs, rw: lcd_rw, data: lcd_data});
			end
		end
	end

	initial begin
		int n_resets;
		int limit;
		int i;
		wait (rows_built);
		n_resets = 0;
		for (i = 0; i < rows.size(); i++) begin
			if (i == 0 || rows[i].cfg != rows[i - 1].cfg) begin
				n_resets++;
			end
		end
		limit = 2 * (n_resets * INIT_US * U +
			rows.size() * ((lcd_pkg::T_CLEAR + lcd_pkg::T_WRITE) * U + SETTLE));
		repeat (limit) @(posedge clk);
		$display("timeout: the run did not finish within %0d cycles", limit);
		$display("errors: %0d, bus writes checked: %0d", errors, checked);
		$display("TEST FAIL");
		$finish;
	end

	initial begin
		int                   i;
		logic                 accepted;
		logic                 saw_full;
		lcd_pkg::lcd_config_t cfg_a;
		lcd_pkg::lcd_config_t cfg_b;
		reset      = 1'b1;
		cfg        = '0;
		char_data  = '0;
		char_write = 1'b0;
		errors     = 0;
		checked    = 0;
		rows_built = 1'b0;
		saw_full   = 1'b0;
		cfg_a = '{two_line: 1'b1, font_5x10: 1'b0, display_on: 1'b1, cursor_on: 1'b1,
			blink_on: 1'b0, increment: 1'b1, shift: 1'b0};
		cfg_b = '{two_line: 1'b0, font_5x10: 1'b1, display_on: 1'b0, cursor_on: 1'b0,
			blink_on: 1'b1, increment: 1'b0, shift: 1'b1};
		add_text(cfg_a, "ABCDE", 1'b0);  // fifth char wraps to line 1
		rows.push_back('{cfg: cfg_a, ch: 8'h0A, burst: 1'b0});
		add_text(cfg_a, "F", 1'b0);
		rows.push_back('{cfg: cfg_a, ch: 8'h0A, burst: 1'b0});
		add_text(cfg_a, "G", 1'b0);
		rows.push_back('{cfg: cfg_a, ch: 8'h0C, burst: 1'b0});  // form feed
		add_text(cfg_a, "H", 1'b0);
		add_text(cfg_a, "abcdefghijkl", 1'b1);  // overruns the 8-deep fifo
		add_text(cfg_b, "WXYZQ", 1'b0);
		rows.push_back('{cfg: cfg_b, ch: 8'h0A, burst: 1'b0});
		add_text(cfg_b, "R", 1'b0);
		rows_built = 1'b1;

		for (i = 0; i < rows.size(); i++) begin
			if (i == 0 || rows[i].cfg != rows[i - 1].cfg) begin
				if (i > 0) begin
					finish_phase();
				end
				restart(rows[i].cfg);
			end else if (rows[i].burst && !rows[i - 1].burst) begin
				finish_phase();  // burst starts from an empty fifo
				saw_full = 1'b0;
			end
			if (!rows[i].burst) begin
				while (char_full) @(negedge clk);
			end
			strobe(rows[i].ch, accepted);
			if (accepted) begin
				model_char(rows[i].ch);
			end else begin
				saw_full = 1'b1;
			end
			if (rows[i].burst && (i + 1 == rows.size() || !rows[i + 1].burst) && !saw_full) begin
				errors++;
				$display("back-pressure burst never raised char_full");
			end
		end
		finish_phase();

		$display("errors: %0d, bus writes checked: %0d", errors, checked);
		if (errors == 0) begin
			$display("TEST PASS");
		end else begin
			$display("TEST FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== sources.f ====
logic/lcd_pkg.sv
logic/char_fifo.sv
logic/text_formatter.sv
logic/lcd_controller.sv
logic/lcd_text_top.sv
dv/lcd_clock_gen.sv
dv/lcd_text_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= lcd_text_tb
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --timescale 1ns/1ps -j 0

SOURCES := $(shell grep -v '^+' $(FILELIST))

.PHONY: all compile run clean

all: run

compile: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -qx "TEST PASS" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
